// File: source/memCtrl_cfg.svh
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// Port counts
`define MEM_NUM_LOADS 2
`define MEM_NUM_STORES 2
`define MEM_NUM_CONTROLS 1

// Word and address widths
`define MEM_DATA_W 32
`define MEM_ADDR_W 6
`define MEM_DEPTH (1 << `MEM_ADDR_W)

`endif

// File: source/memCtrlPkg.sv
`default_nettype none

`include "memCtrl_cfg.svh"

package memCtrlPkg;

  typedef logic [`MEM_ADDR_W-1:0] addrT;

  typedef logic [`MEM_DATA_W-1:0] dataT;

  // Number of stores one basic block will issue
  typedef logic [31:0] ctrlT;

  // One bit wider than a token so that an underflow reads as negative
  typedef logic signed [32:0] storeCountT;

endpackage

`default_nettype wire

// File: source/bramIf.sv
`default_nettype none

interface bramIf;

  logic             loadEn;
  memCtrlPkg::addrT loadAddr;
  memCtrlPkg::dataT loadData;
  logic             storeEn;
  memCtrlPkg::addrT storeAddr;
  memCtrlPkg::dataT storeData;

  // Controller sides
  modport readSide (output loadEn, output loadAddr, input loadData);
  modport writeSide (output storeEn, output storeAddr, output storeData);

  // RAM side
  modport memSide (
    input  loadEn, input loadAddr, output loadData,
    input  storeEn, input storeAddr, input storeData
  );

endinterface

`default_nettype wire

// File: source/storeController.sv
`default_nettype none

`include "memCtrl_cfg.svh"

module storeController (
  input  wire                                    clk,
  input  wire                                    arstN,
  input  wire                                    memStartValid,
  output logic                                   memStartReady,
  output logic                                   memEndValid,
  input  wire                                    memEndReady,
  input  wire                                    ctrlEndValid,
  output logic                                   ctrlEndReady,
  input  wire  [`MEM_NUM_CONTROLS*32-1:0]        ctrl,
  input  wire  [`MEM_NUM_CONTROLS-1:0]           ctrlValid,
  output logic [`MEM_NUM_CONTROLS-1:0]           ctrlReady,
  input  wire  [`MEM_NUM_STORES*`MEM_ADDR_W-1:0] stAddr,
  input  wire  [`MEM_NUM_STORES-1:0]             stAddrValid,
  output logic [`MEM_NUM_STORES-1:0]             stAddrReady,
  input  wire  [`MEM_NUM_STORES*`MEM_DATA_W-1:0] stData,
  input  wire  [`MEM_NUM_STORES-1:0]             stDataValid,
  output logic [`MEM_NUM_STORES-1:0]             stDataReady,
  bramIf.writeSide                               wr
);

  localparam int NumCtrl   = `MEM_NUM_CONTROLS;
  localparam int NumStores = `MEM_NUM_STORES;
  localparam int AddrW     = `MEM_ADDR_W;
  localparam int DataW     = `MEM_DATA_W;
  localparam int CtrlW     = $bits(memCtrlPkg::ctrlT);

  typedef enum logic [1:0] {StIdle, StRunning, StDraining} stateT;

  stateT                  state;
  memCtrlPkg::storeCountT count;
  memCtrlPkg::storeCountT countNext;
  logic                   endHeld;
  logic                   storeActive;
  logic [NumStores-1:0]   stGrant;
  memCtrlPkg::addrT       grantAddr;
  memCtrlPkg::dataT       grantData;

  assign memStartReady = (state == StIdle);
  assign ctrlEndReady  = (state == StRunning);
  assign ctrlReady     = {NumCtrl{state != StIdle}};

  // Once raised, endHeld keeps memEnd up even if the count moves
  assign memEndValid = (state == StDraining) &&
                       (endHeld || (count == '0 && !wr.storeEn));

  // No new stores in the cycle that hands back memEnd
  assign storeActive = (state != StIdle) && !memEndValid;

  // Lowest port with both address and data wins
  always_comb begin
    logic taken;
    taken     = 1'b0;
    stGrant   = '0;
    grantAddr = '0;
    grantData = '0;
    for (int i = 0; i < NumStores; i++) begin
      if (storeActive && stAddrValid[i] && stDataValid[i] && !taken) begin
        stGrant[i] = 1'b1;
        grantAddr  = stAddr[i*AddrW +: AddrW];
        grantData  = stData[i*DataW +: DataW];
        taken      = 1'b1;
      end
    end
  end

  assign stAddrReady = stGrant;
  assign stDataReady = stGrant;

  // Tokens add, each accepted store takes one away
  always_comb begin
    memCtrlPkg::ctrlT token;
    countNext = count;
    for (int k = 0; k < NumCtrl; k++) begin
      token = ctrl[k*CtrlW +: CtrlW];
      if (ctrlValid[k] && ctrlReady[k]) begin
        countNext = countNext + memCtrlPkg::storeCountT'({1'b0, token});
      end
    end
    if (|stGrant) begin
      countNext = countNext - memCtrlPkg::storeCountT'(1);
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= StIdle;
      count      <= '0;
      endHeld    <= 1'b0;
      wr.storeEn <= 1'b0;
    end else begin
      count      <= countNext;
      wr.storeEn <= |stGrant;
      case (state)
        StIdle: begin
          if (memStartValid) state <= StRunning;
        end
        StRunning: begin
          if (ctrlEndValid) state <= StDraining;
        end
        StDraining: begin
          if (memEndValid && memEndReady) begin
            state   <= StIdle;
            endHeld <= 1'b0;
          end else if (memEndValid) begin
            endHeld <= 1'b1;
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  // Write stage
  always_ff @(posedge clk) begin
    if (|stGrant) begin
      wr.storeAddr <= grantAddr;
      wr.storeData <= grantData;
    end
  end

  aOneStore: assert property (@(posedge clk) disable iff (!arstN) $onehot0(stGrant));

  aNoWriteIdle: assert property (@(posedge clk) disable iff (!arstN)
    state == StIdle |-> !wr.storeEn);

  aEndCount: assert property (@(posedge clk) disable iff (!arstN)
    memEndValid |-> count >= 0);

endmodule

`default_nettype wire

// File: source/readArbiter.sv
`default_nettype none

`include "memCtrl_cfg.svh"

module readArbiter (
  input  wire                                   clk,
  input  wire                                   arstN,
  input  wire  [`MEM_NUM_LOADS*`MEM_ADDR_W-1:0] ldAddr,
  input  wire  [`MEM_NUM_LOADS-1:0]             ldAddrValid,
  output logic [`MEM_NUM_LOADS-1:0]             ldAddrReady,
  output logic [`MEM_NUM_LOADS*`MEM_DATA_W-1:0] ldData,
  output logic [`MEM_NUM_LOADS-1:0]             ldDataValid,
  input  wire  [`MEM_NUM_LOADS-1:0]             ldDataReady,
  bramIf.readSide                               rd
);

  localparam int NumLoads = `MEM_NUM_LOADS;
  localparam int AddrW    = `MEM_ADDR_W;
  localparam int DataW    = `MEM_DATA_W;

  // One-hot port whose read is in the RAM this cycle
  logic [NumLoads-1:0] pend;
  logic [NumLoads-1:0] slotFull;
  logic [NumLoads-1:0] grant;
  memCtrlPkg::dataT    retData [NumLoads];

  // A port is blocked by any lower valid port, even one that cannot go
  always_comb begin
    logic lowerValid;
    lowerValid  = 1'b0;
    grant       = '0;
    rd.loadEn   = 1'b0;
    rd.loadAddr = '0;
    for (int i = 0; i < NumLoads; i++) begin
      if (ldAddrValid[i] && !lowerValid && !slotFull[i] && !pend[i]) begin
        grant[i]    = 1'b1;
        rd.loadEn   = 1'b1;
        rd.loadAddr = ldAddr[i*AddrW +: AddrW];
      end
      lowerValid = lowerValid | ldAddrValid[i];
    end
  end

  assign ldAddrReady = grant;

  // Fresh RAM data goes straight out, parked data comes from the slot
  always_comb begin
    for (int i = 0; i < NumLoads; i++) begin
      ldDataValid[i]           = slotFull[i] || pend[i];
      ldData[i*DataW +: DataW] = slotFull[i] ? retData[i] : rd.loadData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pend     <= '0;
      slotFull <= '0;
    end else begin
      pend <= grant;
      for (int i = 0; i < NumLoads; i++) begin
        if (pend[i] && !ldDataReady[i]) begin
          slotFull[i] <= 1'b1;
        end else if (slotFull[i] && ldDataReady[i]) begin
          slotFull[i] <= 1'b0;
        end
      end
    end
  end

  // Park RAM output when the port is back-pressured
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumLoads; i++) begin
      if (pend[i] && !ldDataReady[i]) begin
        retData[i] <= rd.loadData;
      end
    end
  end

  aOneGrant: assert property (@(posedge clk) disable iff (!arstN) $onehot0(grant));

  for (genvar g = 0; g < NumLoads; g++) begin : gHold
    aHold: assert property (@(posedge clk) disable iff (!arstN)
      ldDataValid[g] && !ldDataReady[g] |=>
        ldDataValid[g] && $stable(ldData[g*DataW +: DataW]));
  end

endmodule

`default_nettype wire

// File: source/memController.sv
`default_nettype none

`include "memCtrl_cfg.svh"

module memController (
  input  wire                                    clk,
  input  wire                                    arstN,
  input  wire                                    memStartValid,
  output logic                                   memStartReady,
  output logic                                   memEndValid,
  input  wire                                    memEndReady,
  input  wire                                    ctrlEndValid,
  output logic                                   ctrlEndReady,
  input  wire  [`MEM_NUM_CONTROLS*32-1:0]        ctrl,
  input  wire  [`MEM_NUM_CONTROLS-1:0]           ctrlValid,
  output logic [`MEM_NUM_CONTROLS-1:0]           ctrlReady,
  input  wire  [`MEM_NUM_LOADS*`MEM_ADDR_W-1:0]  ldAddr,
  input  wire  [`MEM_NUM_LOADS-1:0]              ldAddrValid,
  output logic [`MEM_NUM_LOADS-1:0]              ldAddrReady,
  output logic [`MEM_NUM_LOADS*`MEM_DATA_W-1:0]  ldData,
  output logic [`MEM_NUM_LOADS-1:0]              ldDataValid,
  input  wire  [`MEM_NUM_LOADS-1:0]              ldDataReady,
  input  wire  [`MEM_NUM_STORES*`MEM_ADDR_W-1:0] stAddr,
  input  wire  [`MEM_NUM_STORES-1:0]             stAddrValid,
  output logic [`MEM_NUM_STORES-1:0]             stAddrReady,
  input  wire  [`MEM_NUM_STORES*`MEM_DATA_W-1:0] stData,
  input  wire  [`MEM_NUM_STORES-1:0]             stDataValid,
  output logic [`MEM_NUM_STORES-1:0]             stDataReady,
  bramIf                                         ram
);

  // Write port and token handling
  storeController storeInst (
    .clk          (clk),
    .arstN        (arstN),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .wr           (ram.writeSide)
  );

  // Read port
  readArbiter loadInst (
    .clk        (clk),
    .arstN      (arstN),
    .ldAddr     (ldAddr),
    .ldAddrValid(ldAddrValid),
    .ldAddrReady(ldAddrReady),
    .ldData     (ldData),
    .ldDataValid(ldDataValid),
    .ldDataReady(ldDataReady),
    .rd         (ram.readSide)
  );

  // memEnd only once every returned load has been taken
  aEndAfterLoads: assert property (@(posedge clk) disable iff (!arstN)
    $rose(memEndValid) |-> !(|(ldDataValid & ~ldDataReady)));

endmodule

`default_nettype wire

// File: source/dualPortBram.sv
`default_nettype none

`include "memCtrl_cfg.svh"

module dualPortBram (
  input  wire    clk,
  bramIf.memSide mem
);

  localparam int Depth = `MEM_DEPTH;

  memCtrlPkg::dataT memArray [Depth];

  // Write port
  always_ff @(posedge clk) begin
    if (mem.storeEn) begin
      memArray[mem.storeAddr] <= mem.storeData;
    end
  end

  // Read data register holds between reads
  always_ff @(posedge clk) begin
    if (mem.loadEn) begin
      mem.loadData <= memArray[mem.loadAddr];
    end
  end

endmodule

`default_nettype wire

// File: source/memSubsystem.sv
`default_nettype none

`include "memCtrl_cfg.svh"

module memSubsystem (
  input  wire                                    clk,
  input  wire                                    arstN,
  input  wire                                    memStartValid,
  output logic                                   memStartReady,
  output logic                                   memEndValid,
  input  wire                                    memEndReady,
  input  wire                                    ctrlEndValid,
  output logic                                   ctrlEndReady,
  input  wire  [`MEM_NUM_CONTROLS*32-1:0]        ctrl,
  input  wire  [`MEM_NUM_CONTROLS-1:0]           ctrlValid,
  output logic [`MEM_NUM_CONTROLS-1:0]           ctrlReady,
  input  wire  [`MEM_NUM_LOADS*`MEM_ADDR_W-1:0]  ldAddr,
  input  wire  [`MEM_NUM_LOADS-1:0]              ldAddrValid,
  output logic [`MEM_NUM_LOADS-1:0]              ldAddrReady,
  output logic [`MEM_NUM_LOADS*`MEM_DATA_W-1:0]  ldData,
  output logic [`MEM_NUM_LOADS-1:0]              ldDataValid,
  input  wire  [`MEM_NUM_LOADS-1:0]              ldDataReady,
  input  wire  [`MEM_NUM_STORES*`MEM_ADDR_W-1:0] stAddr,
  input  wire  [`MEM_NUM_STORES-1:0]             stAddrValid,
  output logic [`MEM_NUM_STORES-1:0]             stAddrReady,
  input  wire  [`MEM_NUM_STORES*`MEM_DATA_W-1:0] stData,
  input  wire  [`MEM_NUM_STORES-1:0]             stDataValid,
  output logic [`MEM_NUM_STORES-1:0]             stDataReady
);

  // Shared RAM ports
  bramIf ramBus ();

  memController ctrlInst (
    .clk          (clk),
    .arstN        (arstN),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .ldAddr       (ldAddr),
    .ldAddrValid  (ldAddrValid),
    .ldAddrReady  (ldAddrReady),
    .ldData       (ldData),
    .ldDataValid  (ldDataValid),
    .ldDataReady  (ldDataReady),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .ram          (ramBus)
  );

  dualPortBram ramInst (
    .clk(clk),
    .mem(ramBus.memSide)
  );

endmodule

`default_nettype wire

// File: verification/tbMemSubsystem.sv
`default_nettype none

`include "memCtrl_cfg.svh"

module tbMemSubsystem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumLoads     = `MEM_NUM_LOADS;
  localparam int NumStores    = `MEM_NUM_STORES;
  localparam int NumCtrl      = `MEM_NUM_CONTROLS;
  localparam int AddrW        = `MEM_ADDR_W;
  localparam int DataW        = `MEM_DATA_W;
  localparam int NumWrites    = 24;
  localparam int LoadsPerPort = 32;
  // Traffic needs a few hundred cycles at most
  localparam int TimeoutCycles = 4000;

  logic                        clk;
  logic                        arstN;
  logic                        memStartValid;
  logic                        memStartReady;
  logic                        memEndValid;
  logic                        memEndReady;
  logic                        ctrlEndValid;
  logic                        ctrlEndReady;
  logic [NumCtrl*32-1:0]       ctrl;
  logic [NumCtrl-1:0]          ctrlValid;
  logic [NumCtrl-1:0]          ctrlReady;
  logic [NumLoads*AddrW-1:0]   ldAddr;
  logic [NumLoads-1:0]         ldAddrValid;
  logic [NumLoads-1:0]         ldAddrReady;
  logic [NumLoads*DataW-1:0]   ldData;
  logic [NumLoads-1:0]         ldDataValid;
  logic [NumLoads-1:0]         ldDataReady;
  logic [NumStores*AddrW-1:0]  stAddr;
  logic [NumStores-1:0]        stAddrValid;
  logic [NumStores-1:0]        stAddrReady;
  logic [NumStores*DataW-1:0]  stData;
  logic [NumStores-1:0]        stDataValid;
  logic [NumStores-1:0]        stDataReady;

  // Reference memory and per-port request history
  memCtrlPkg::dataT model [`MEM_DEPTH];
  memCtrlPkg::addrT written [NumWrites];
  memCtrlPkg::addrT reqAddr [NumLoads][LoadsPerPort+1];
  memCtrlPkg::dataT expData [NumLoads];
  int               reqWr [NumLoads];
  int               reqRd [NumLoads];
  int               sessionStores;
  int               storeTarget;
  int               cycles = 0;
  integer           seed;
  logic             idleWindow;
  logic             storeWindow;
  logic [2*NumLoads+NumStores+NumCtrl+1:0] idleBusy;

  memSubsystem uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stopWithError(input string line);
    $display("CHECKS FAILED");
    $display("%s", line);
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) stopWithError("The run timed out waiting for the DUT");
  end

  always_comb begin
    for (int p = 0; p < NumLoads; p++) begin
      expData[p] = model[reqAddr[p][reqRd[p]]];
    end
  end

  assign idleBusy = {memEndValid, ldDataValid, stAddrReady, ldAddrReady, ctrlReady,
                     ctrlEndReady};

  aIdle: assert property (@(posedge clk) disable iff (!arstN)
    idleWindow |-> idleBusy == '0 && memStartReady)
    else stopWithError($sformatf("Error idle outputs got 0x%h expected 0x0, memStartReady 0x%h",
                                 $sampled(idleBusy), $sampled(memStartReady)));

  aEndCount: assert property (@(posedge clk) disable iff (!arstN)
    memEndValid |-> sessionStores == storeTarget)
    else stopWithError($sformatf("Error memEndValid with store count 0x%h expected 0x%h",
                                 $sampled(sessionStores), $sampled(storeTarget)));

  aEndHold: assert property (@(posedge clk) disable iff (!arstN)
    memEndValid && !memEndReady |=> memEndValid)
    else stopWithError("Error memEndValid got 0x0 expected 0x1 before memEndReady");

  aStorePrio: assert property (@(posedge clk) disable iff (!arstN)
    storeWindow && (&stAddrValid) && (&stDataValid) |->
      stAddrReady == {{(NumStores-1){1'b0}}, 1'b1})
    else stopWithError($sformatf("Error stAddrReady got 0x%h expected 0x1",
                                 $sampled(stAddrReady)));

  // Address and data of a store transfer together
  aStorePair: assert property (@(posedge clk) disable iff (!arstN)
    stDataReady == stAddrReady)
    else stopWithError($sformatf("Error stDataReady got 0x%h expected 0x%h",
                                 $sampled(stDataReady), $sampled(stAddrReady)));

  // Port 0 goes first whenever its slot is free
  aLoadPrio: assert property (@(posedge clk) disable iff (!arstN)
    &ldAddrValid |-> ldAddrReady == {{(NumLoads-1){1'b0}}, !ldDataValid[0]})
    else stopWithError($sformatf("Error ldAddrReady got 0x%h expected 0x%h",
                                 $sampled(ldAddrReady), $sampled(!ldDataValid[0])));

  for (genvar g = 0; g < NumLoads; g++) begin : gLoadChecks
    aData: assert property (@(posedge clk) disable iff (!arstN)
      ldDataValid[g] && ldDataReady[g] |-> ldData[g*DataW +: DataW] == expData[g])
      else stopWithError($sformatf("Error ldData[%0d] got 0x%h expected 0x%h", g,
                                   $sampled(ldData[g*DataW +: DataW]), $sampled(expData[g])));

    aOwed: assert property (@(posedge clk) disable iff (!arstN)
      ldDataValid[g] |-> reqRd[g] < reqWr[g])
      else stopWithError($sformatf("Load port %0d returned data it never asked for", g));

    aHeld: assert property (@(posedge clk) disable iff (!arstN)
      ldDataValid[g] && !ldDataReady[g] |=>
        ldDataValid[g] && $stable(ldData[g*DataW +: DataW]))
      else stopWithError($sformatf("Error ldData[%0d] got 0x%h expected held 0x%h", g,
                                   $sampled(ldData[g*DataW +: DataW]),
                                   $past(ldData[g*DataW +: DataW])));

    aBlocked: assert property (@(posedge clk) disable iff (!arstN)
      ldDataValid[g] && !ldDataReady[g] |-> !ldAddrReady[g])
      else stopWithError($sformatf("Error ldAddrReady[%0d] got 0x1 expected 0x0", g));
  end

  task automatic sendStart();
    memStartValid <= 1'b1;
    do @(posedge clk); while (!memStartReady);
    memStartValid <= 1'b0;
    sessionStores = 0;
  endtask

  task automatic sendCtrl(input memCtrlPkg::ctrlT count);
    ctrl[31:0]   <= count;
    ctrlValid[0] <= 1'b1;
    do @(posedge clk); while (!ctrlReady[0]);
    ctrlValid[0] <= 1'b0;
  endtask

  task automatic sendCtrlEnd();
    ctrlEndValid <= 1'b1;
    do @(posedge clk); while (!ctrlEndReady);
    ctrlEndValid <= 1'b0;
  endtask

  // Random stall before taking memEnd
  task automatic takeMemEnd();
    int delay;
    delay = $random(seed) & 32'h3;
    do @(posedge clk); while (!memEndValid);
    repeat (delay) @(posedge clk);
    memEndReady <= 1'b1;
    @(posedge clk);
    memEndReady <= 1'b0;
  endtask

  task automatic runStores(input int total);
    int               issued;
    logic             free;
    memCtrlPkg::addrT curAddr [NumStores];
    memCtrlPkg::dataT curData [NumStores];
    issued      = 0;
    storeWindow = 1'b1;
    while (sessionStores < total) begin
      for (int p = 0; p < NumStores; p++) begin
        free = !stAddrValid[p] || stAddrReady[p];
        if (stAddrValid[p] && stAddrReady[p]) begin
          model[curAddr[p]]      = curData[p];
          written[sessionStores] = curAddr[p];
          sessionStores++;
          stAddrValid[p] <= 1'b0;
          stDataValid[p] <= 1'b0;
        end
        if (free && issued < total && ($random(seed) & 32'h3) != 0) begin
          curAddr[p] = AddrW'($random(seed));
          curData[p] = DataW'($random(seed));
          stAddr[p*AddrW +: AddrW] <= curAddr[p];
          stData[p*DataW +: DataW] <= curData[p];
          stAddrValid[p] <= 1'b1;
          stDataValid[p] <= 1'b1;
          issued++;
        end
      end
      @(posedge clk);
    end
    storeWindow = 1'b0;
  endtask

  task automatic runLoads(input int perPort);
    int   issued [NumLoads];
    int   returned;
    int   idx;
    logic hold;
    returned = 0;
    for (int p = 0; p < NumLoads; p++) issued[p] = 0;
    while (returned < NumLoads * perPort) begin
      for (int p = 0; p < NumLoads; p++) begin
        hold = ldAddrValid[p] && !ldAddrReady[p];
        if (ldAddrValid[p] && ldAddrReady[p]) begin
          reqAddr[p][reqWr[p]] = ldAddr[p*AddrW +: AddrW];
          reqWr[p]++;
        end
        if (ldDataValid[p] && ldDataReady[p]) begin
          reqRd[p]++;
          returned++;
        end
        if (!hold) begin
          if (issued[p] < perPort && ($random(seed) & 32'h1) != 0) begin
            idx = ($random(seed) & 32'h7fff_ffff) % NumWrites;
            ldAddr[p*AddrW +: AddrW] <= written[idx];
            ldAddrValid[p] <= 1'b1;
            issued[p]++;
          end else begin
            ldAddrValid[p] <= 1'b0;
          end
        end
        ldDataReady[p] <= (($random(seed) & 32'h3) != 0);
      end
      @(posedge clk);
    end
    ldDataReady <= '0;
  endtask

  initial begin
    seed          = 32'h9dd864b9;
    arstN         = 1'b0;
    memStartValid = 1'b0;
    memEndReady   = 1'b0;
    ctrlEndValid  = 1'b0;
    ctrl          = '0;
    ctrlValid     = '0;
    ldAddr        = '0;
    ldAddrValid   = '0;
    ldDataReady   = '0;
    stAddr        = '0;
    stAddrValid   = '0;
    stData        = '0;
    stDataValid   = '0;
    idleWindow    = 1'b0;
    storeWindow   = 1'b0;
    sessionStores = 0;
    storeTarget   = 0;
    for (int p = 0; p < NumLoads; p++) begin
      reqWr[p] = 0;
      reqRd[p] = 0;
    end
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);
    idleWindow <= 1'b1;
    repeat (3) @(posedge clk);
    idleWindow <= 0;
    // Write session
    storeTarget = NumWrites;
    sendStart();
    sendCtrl(NumWrites);
    // End token overlaps the store traffic so memEnd has to wait on the count
    fork
      runStores(NumWrites);
      sendCtrlEnd();
    join
    takeMemEnd();
    // Read back, then close an empty session
    runLoads(LoadsPerPort);
    storeTarget = 0;
    sendStart();
    sendCtrl(0);
    sendCtrlEnd();
    takeMemEnd();
    repeat (2) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: memSubsystem.f
+incdir+source
source/memCtrlPkg.sv
source/bramIf.sv
source/storeController.sv
source/readArbiter.sv
source/memController.sv
source/dualPortBram.sv
source/memSubsystem.sv
verification/tbMemSubsystem.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench
# Override any variable on the command line, e.g. make sim TOP=tbMemSubsystem

VERILATOR ?= verilator
TOP       ?= tbMemSubsystem
FILELIST  ?= memSubsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
